// ==== src.f ====
+incdir+tests
hdl/tetrisPkg.sv
hdl/boardStore.sv
hdl/pieceChecker.sv
hdl/rowScanner.sv
hdl/gameControl.sv
hdl/tetrisTop.sv
tests/tetrisTb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f src.f --top-module tetrisTb -o tetrisSim \
	&& ./obj_dir/tetrisSim || exit 1

// ==== tests/tetrisModel.svh ====
localparam int W = tetrisPkg::DefaultWidth;
localparam int H = tetrisPkg::DefaultHeight;
localparam int CmdLeft = 0;
localparam int CmdRight = 1;
localparam int CmdFall = 2;
localparam int CmdRestart = 3;
localparam int Square = int'(tetrisPkg::ShapeSquare);
localparam int HBar = int'(tetrisPkg::ShapeHBar);
localparam int VBar = int'(tetrisPkg::ShapeVBar);
localparam int TShape = int'(tetrisPkg::ShapeT);

// Expected game state
logic [W-1:0] mBoard [H];	// Locked cells, bit c is column c
int mRow;
int mCol;
int mShape;
int mScore;
bit mOver;
bit mLocked;	// Set when the last command locked a piece
logic [31:0] lcgState = 32'hd99d_4703;

// Value in 0..n-1 from the upper LCG bits
function automatic int lcgPick(int n);
	lcgState = lcgState * 32'd1664525 + 32'd1013904223;
	return int'(lcgState[31:16]) % n;
endfunction

function automatic bit fits(int r, int c, int s);
	int rr;
	int cc;
	for (int k = 0; k < 4; k++) begin
		rr = r + int'(tetrisPkg::ShapeRowOff[s][k]);
		cc = c + int'(tetrisPkg::ShapeColOff[s][k]);
		if (rr < 0 || rr >= H || cc < 0 || cc >= W)
			return 1'b0;
		if (mBoard[rr][cc])
			return 1'b0;
	end
	return 1'b1;
endfunction

function automatic void modelSpawn(int s);
	mShape = s;
	mRow = 0;
	mCol = W / 2 - 1;
endfunction

function automatic void modelLock();
	int r;
	for (int k = 0; k < 4; k++)
		mBoard[mRow + int'(tetrisPkg::ShapeRowOff[mShape][k])]
			[mCol + int'(tetrisPkg::ShapeColOff[mShape][k])] = 1'b1;
	r = H - 1;
	while (r >= 0) begin
		if (&mBoard[r]) begin
			for (int i = r; i > 0; i--)
				mBoard[i] = mBoard[i - 1];
			mBoard[0] = '0;
			mScore++;	// Same row index is tested again after the shift
		end else
			r--;
	end
	for (int i = 0; i < tetrisPkg::SpawnRows; i++)
		if (|mBoard[i])
			mOver = 1'b1;
endfunction

// One command, s is the shape offered for any spawn it causes
function automatic void modelApply(int cmd, int s);
	mLocked = 1'b0;
	if (mOver) begin
		if (cmd == CmdRestart) begin
			for (int i = 0; i < H; i++)
				mBoard[i] = '0;
			mScore = 0;
			mOver = 1'b0;
			modelSpawn(s);
		end
	end else if (cmd == CmdLeft) begin
		if (fits(mRow, mCol - 1, mShape))
			mCol--;
	end else if (cmd == CmdRight) begin
		if (fits(mRow, mCol + 1, mShape))
			mCol++;
	end else if (cmd == CmdFall) begin
		if (fits(mRow + 1, mCol, mShape))
			mRow++;
		else begin
			modelLock();
			mLocked = 1'b1;
			if (!mOver)
				modelSpawn(s);
		end
	end
endfunction

// ==== tests/tetrisTb.sv ====
`timescale 1ns/100ps

module tetrisTb;

	`include "tetrisModel.svh"

	logic count;
	logic rst;
	logic moveLeft;
	logic moveRight;
	logic fallTick;
	logic restart;
	tetrisPkg::shapeT shapeSel;
	tetrisPkg::rowIdxT rowSel;
	logic ready;
	logic gameOver;
	tetrisPkg::scoreT score;
	tetrisPkg::rowIdxT pieceRow;
	tetrisPkg::colIdxT pieceCol;
	tetrisPkg::shapeT pieceShape;
	logic [W-1:0] rowData;
	bit checkReq;	// Stimulus asks the comparison process for a full check

	tetrisTop dut_i (.*);

	initial begin
		count = 1'b0;
		forever #10 count = ~count;
	end

	task automatic failNow(string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(string name, int got, int exp);
		assert (got == exp) else
			failNow($sformatf("error %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic waitIdle();
		int n;
		n = 0;
		while (!(ready || gameOver)) begin
			@(negedge count);
			n++;
			if (n > 50)
				failNow("timeout: neither ready nor gameOver came back after a command");
		end
	endtask

	task automatic waitCompare();
		int n;
		n = 0;
		while (checkReq) begin
			@(negedge count);
			n++;
			if (n > 2 * H + 4)
				failNow("timeout: the comparison process never finished");
		end
	endtask

	// One strobe for one cycle, then compare everything
	task automatic doCommand(int cmd, int s);
		waitIdle();
		modelApply(cmd, s);
		shapeSel = tetrisPkg::shapeT'(s);
		moveLeft = (cmd == CmdLeft);
		moveRight = (cmd == CmdRight);
		fallTick = (cmd == CmdFall);
		restart = (cmd == CmdRestart);
		@(negedge count);
		{moveLeft, moveRight, fallTick, restart} = 4'b0;
		waitIdle();
		checkReq = 1'b1;
		waitCompare();
	endtask

	task automatic moveTimes(int cmd, int n, int s);
		repeat (n) doCommand(cmd, s);
	endtask

	task automatic dropPiece(int nextShape);
		for (int i = 0; i <= H; i++) begin
			doCommand(CmdFall, nextShape);
			if (mLocked || mOver)
				break;
		end
	endtask

	initial begin
		forever begin
			@(negedge count);
			if (checkReq) begin
				checkValue("pieceRow", int'(pieceRow), mRow);
				checkValue("pieceCol", int'(pieceCol), mCol);
				checkValue("pieceShape", int'(pieceShape), mShape);
				checkValue("score", int'(score), mScore);
				checkValue("gameOver", int'(gameOver), int'(mOver));
				checkValue("ready", int'(ready), int'(!mOver));
				rowSel = '0;	// One row per cycle through the read port
				for (int r = 0; r < H; r++) begin
					@(negedge count);
					checkValue($sformatf("rowData[%0d]", r), int'(rowData), int'(mBoard[r]));
					rowSel = tetrisPkg::rowIdxT'(r + 1);
				end
				checkReq = 1'b0;
			end
		end
	end

	initial begin
		int pick;
		{moveLeft, moveRight, fallTick, restart} = 4'b0;
		shapeSel = tetrisPkg::ShapeT;
		rowSel = '0;
		checkReq = 1'b0;
		rst = 1'b1;
		for (int i = 0; i < H; i++)
			mBoard[i] = '0;
		mScore = 0;
		mOver = 1'b0;
		modelSpawn(TShape);
		repeat (3) @(negedge count);
		rst = 1'b0;
		waitIdle();
		checkReq = 1'b1;	// First spawn on an empty board
		waitCompare();
		moveTimes(CmdLeft, 6, TShape);	// Stops at the left wall
		moveTimes(CmdRight, 9, TShape);
		dropPiece(VBar);
		moveTimes(CmdFall, 16, VBar);
		moveTimes(CmdRight, 4, VBar);	// Blocked by the locked T
		dropPiece(VBar);
		for (int i = 0; i < 3; i++)
			dropPiece(VBar);
		dropPiece(Square);	// Fourth bar tops out at row 4
		dropPiece(Square);	// Square stops in rows 2 and 3 with row 0 still empty
		checkValue("gameOver", int'(gameOver), 1);
		doCommand(CmdLeft, Square);	// Ignored while over
		doCommand(CmdFall, Square);
		doCommand(CmdRestart, HBar);
		// Two bar rows closed by one square, then a single row
		moveTimes(CmdLeft, 4, HBar);
		dropPiece(HBar);
		dropPiece(HBar);
		moveTimes(CmdLeft, 4, HBar);
		dropPiece(HBar);
		dropPiece(Square);
		moveTimes(CmdRight, 4, Square);
		dropPiece(HBar);
		checkValue("score", int'(score), 2);
		moveTimes(CmdLeft, 4, HBar);
		dropPiece(HBar);
		dropPiece(Square);
		moveTimes(CmdRight, 4, Square);
		dropPiece(TShape);
		checkValue("score", int'(score), 3);
		for (int i = 0; i < 600; i++) begin
			pick = lcgPick(8);
			doCommand(pick < 2 ? CmdLeft : pick < 4 ? CmdRight : pick < 7 ? CmdFall : CmdRestart,
				lcgPick(4));
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== hdl/tetrisTop.sv ====
`timescale 1ns/100ps

module tetrisTop #(
	parameter int BoardWidth = tetrisPkg::DefaultWidth,
	parameter int BoardHeight = tetrisPkg::DefaultHeight
) (
	input logic count,
	input logic rst,
	input logic moveLeft,
	input logic moveRight,
	input logic fallTick,
	input logic restart,
	input tetrisPkg::shapeT shapeSel,
	input tetrisPkg::rowIdxT rowSel,
	output logic ready,
	output logic gameOver,
	output tetrisPkg::scoreT score,
	output tetrisPkg::rowIdxT pieceRow,
	output tetrisPkg::colIdxT pieceCol,
	output tetrisPkg::shapeT pieceShape,
	output logic [BoardWidth-1:0] rowData
);

	logic [BoardWidth*BoardHeight-1:0] boardFlat;
	logic canLeft;
	logic canRight;
	logic canDown;
	logic fullFound;
	tetrisPkg::rowIdxT fullRow;
	logic topBusy;
	logic lockPiece;
	logic clearRow;
	tetrisPkg::rowIdxT clearIdx;
	logic wipeBoard;

	boardStore #(
		.BoardWidth(BoardWidth),
		.BoardHeight(BoardHeight)
	) board_i (
		.count(count),
		.rst(rst),
		.lockPiece(lockPiece),
		.pieceRow(pieceRow),
		.pieceCol(pieceCol),
		.pieceShape(pieceShape),
		.clearRow(clearRow),
		.clearIdx(clearIdx),
		.wipeBoard(wipeBoard),
		.rowSel(rowSel),
		.boardFlat(boardFlat),
		.rowData(rowData)
	);

	// Checker and scanner look at the same board in parallel
	pieceChecker #(
		.BoardWidth(BoardWidth),
		.BoardHeight(BoardHeight)
	) checker_i (
		.boardFlat(boardFlat),
		.pieceRow(pieceRow),
		.pieceCol(pieceCol),
		.pieceShape(pieceShape),
		.canLeft(canLeft),
		.canRight(canRight),
		.canDown(canDown)
	);

	rowScanner #(
		.BoardWidth(BoardWidth),
		.BoardHeight(BoardHeight)
	) scanner_i (
		.boardFlat(boardFlat),
		.fullFound(fullFound),
		.fullRow(fullRow),
		.topBusy(topBusy)
	);

	gameControl #(
		.BoardWidth(BoardWidth)
	) control_i (
		.count(count),
		.rst(rst),
		.moveLeft(moveLeft),
		.moveRight(moveRight),
		.fallTick(fallTick),
		.restart(restart),
		.shapeSel(shapeSel),
		.canLeft(canLeft),
		.canRight(canRight),
		.canDown(canDown),
		.fullFound(fullFound),
		.fullRow(fullRow),
		.topBusy(topBusy),
		.pieceRow(pieceRow),
		.pieceCol(pieceCol),
		.pieceShape(pieceShape),
		.lockPiece(lockPiece),
		.clearRow(clearRow),
		.clearIdx(clearIdx),
		.wipeBoard(wipeBoard),
		.ready(ready),
		.gameOver(gameOver),
		.score(score)
	);

endmodule

// ==== hdl/gameControl.sv ====
`timescale 1ns/100ps

module gameControl #(
	parameter int BoardWidth = tetrisPkg::DefaultWidth
) (
	input logic count,
	input logic rst,
	input logic moveLeft,
	input logic moveRight,
	input logic fallTick,
	input logic restart,
	input tetrisPkg::shapeT shapeSel,
	input logic canLeft,
	input logic canRight,
	input logic canDown,
	input logic fullFound,
	input tetrisPkg::rowIdxT fullRow,
	input logic topBusy,
	output tetrisPkg::rowIdxT pieceRow,
	output tetrisPkg::colIdxT pieceCol,
	output tetrisPkg::shapeT pieceShape,
	output logic lockPiece,
	output logic clearRow,
	output tetrisPkg::rowIdxT clearIdx,
	output logic wipeBoard,
	output logic ready,
	output logic gameOver,
	output tetrisPkg::scoreT score
);

	localparam tetrisPkg::colIdxT SpawnCol = tetrisPkg::colIdxT'(BoardWidth / 2 - 1);

	tetrisPkg::ctrlStateT state;

	always_ff @(posedge count) begin
		if (rst) begin
			state <= tetrisPkg::Spawn;
			score <= '0;
			pieceRow <= '0;
			pieceCol <= '0;
			pieceShape <= '0;
		end else begin
			case (state)
				tetrisPkg::Spawn: begin
					pieceShape <= shapeSel;	// Sampled only here
					pieceRow <= '0;
					pieceCol <= SpawnCol;
					state <= tetrisPkg::Play;
				end

				tetrisPkg::Play: begin
					// Left beats right beats fall, the rest is dropped
					if (moveLeft) begin
						if (canLeft)
							pieceCol <= pieceCol - 1'b1;
					end else if (moveRight) begin
						if (canRight)
							pieceCol <= pieceCol + 1'b1;
					end else if (fallTick) begin
						if (canDown)
							pieceRow <= pieceRow + 1'b1;
						else
							state <= tetrisPkg::Lock;
					end
				end

				tetrisPkg::Lock: state <= tetrisPkg::Clear;	// Board takes the piece this cycle

				tetrisPkg::Clear: begin
					// One row per cycle until the scanner runs dry
					if (fullFound)
						score <= score + 1'b1;
					else
						state <= tetrisPkg::CheckTop;
				end

				tetrisPkg::CheckTop: begin
					if (topBusy)
						state <= tetrisPkg::Over;
					else
						state <= tetrisPkg::Spawn;
				end

				tetrisPkg::Over: begin
					if (restart) begin
						score <= '0;
						state <= tetrisPkg::Spawn;
					end
				end

				default: state <= tetrisPkg::Spawn;
			endcase
		end
	end

	assign ready = (state == tetrisPkg::Play);
	assign gameOver = (state == tetrisPkg::Over);

	// Board strobes, one cycle each
	assign lockPiece = (state == tetrisPkg::Lock);
	assign clearRow = (state == tetrisPkg::Clear) && fullFound;
	assign clearIdx = fullRow;
	assign wipeBoard = gameOver && restart;	// Board empties with the same edge as score

endmodule

// ==== hdl/rowScanner.sv ====
`timescale 1ns/100ps

module rowScanner #(
	parameter int BoardWidth = tetrisPkg::DefaultWidth,
	parameter int BoardHeight = tetrisPkg::DefaultHeight
) (
	input logic [BoardWidth*BoardHeight-1:0] boardFlat,
	output logic fullFound,
	output tetrisPkg::rowIdxT fullRow,
	output logic topBusy
);

	logic [BoardHeight-1:0] fullFlag;	// One per row

	genvar g;
	generate
		for (g = 0; g < BoardHeight; g++) begin : fullGen
			assign fullFlag[g] = &boardFlat[g*BoardWidth +: BoardWidth];
		end
	endgenerate

	// Later rows win, so this ends on the bottom-most full row
	always_comb begin
		fullRow = '0;
		for (int r = 0; r < BoardHeight; r++) begin
			if (fullFlag[r])
				fullRow = tetrisPkg::rowIdxT'(r);
		end
	end

	assign fullFound = |fullFlag;

	// Rows 0..SpawnRows-1 are the lowest bits of the flat board
	assign topBusy = |boardFlat[tetrisPkg::SpawnRows*BoardWidth-1:0];

endmodule

// ==== hdl/pieceChecker.sv ====
`timescale 1ns/100ps

module pieceChecker #(
	parameter int BoardWidth = tetrisPkg::DefaultWidth,
	parameter int BoardHeight = tetrisPkg::DefaultHeight
) (
	input logic [BoardWidth*BoardHeight-1:0] boardFlat,
	input tetrisPkg::rowIdxT pieceRow,
	input tetrisPkg::colIdxT pieceCol,
	input tetrisPkg::shapeT pieceShape,
	output logic canLeft,
	output logic canRight,
	output logic canDown
);

	// True when the cell is on the board and not locked
	function automatic logic cellFree(
		input int r,
		input int c,
		input logic [BoardWidth*BoardHeight-1:0] board
	);
		logic free;
		free = 1'b0;
		if (r >= 0 && r < BoardHeight && c >= 0 && c < BoardWidth)
			free = !board[r*BoardWidth + c];
		return free;
	endfunction

	always_comb begin
		int r;
		int c;
		canLeft = 1'b1;
		canRight = 1'b1;
		canDown = 1'b1;
		for (int k = 0; k < 4; k++) begin
			r = int'(pieceRow) + int'(tetrisPkg::ShapeRowOff[pieceShape][k]);
			c = int'(pieceCol) + int'(tetrisPkg::ShapeColOff[pieceShape][k]);
			// Signed math so column -1 fails the bound test
			canLeft = canLeft & cellFree(r, c - 1, boardFlat);
			canRight = canRight & cellFree(r, c + 1, boardFlat);
			canDown = canDown & cellFree(r + 1, c, boardFlat);
		end
	end

endmodule

// ==== hdl/boardStore.sv ====
`timescale 1ns/100ps

module boardStore #(
	parameter int BoardWidth = tetrisPkg::DefaultWidth,
	parameter int BoardHeight = tetrisPkg::DefaultHeight
) (
	input logic count,
	input logic rst,
	input logic lockPiece,
	input tetrisPkg::rowIdxT pieceRow,
	input tetrisPkg::colIdxT pieceCol,
	input tetrisPkg::shapeT pieceShape,
	input logic clearRow,
	input tetrisPkg::rowIdxT clearIdx,
	input logic wipeBoard,
	input tetrisPkg::rowIdxT rowSel,
	output logic [BoardWidth*BoardHeight-1:0] boardFlat,
	output logic [BoardWidth-1:0] rowData
);

	logic [BoardWidth-1:0] rows [BoardHeight];	// Locked cells only, bit c is column c

	always_ff @(posedge count) begin
		int r;
		int c;
		if (rst || wipeBoard) begin
			for (int i = 0; i < BoardHeight; i++)
				rows[i] <= '0;
		end else if (lockPiece) begin
			// Stamp the four cells of the active piece
			for (int k = 0; k < 4; k++) begin
				r = int'(pieceRow) + int'(tetrisPkg::ShapeRowOff[pieceShape][k]);
				c = int'(pieceCol) + int'(tetrisPkg::ShapeColOff[pieceShape][k]);
				if (r < BoardHeight && c < BoardWidth)
					rows[r][c] <= 1'b1;
			end
		end else if (clearRow) begin
			// Everything above clearIdx drops one row
			for (int i = 1; i < BoardHeight; i++) begin
				if (i <= int'(clearIdx))
					rows[i] <= rows[i-1];
			end
			rows[0] <= '0;
		end
	end

	// Row r sits at bits [r*BoardWidth +: BoardWidth]
	genvar g;
	generate
		for (g = 0; g < BoardHeight; g++) begin : flatGen
			assign boardFlat[g*BoardWidth +: BoardWidth] = rows[g];
		end
	endgenerate

	assign rowData = (int'(rowSel) < BoardHeight) ? rows[rowSel] : '0;	// Off-board reads as empty

endmodule

// ==== hdl/tetrisPkg.sv ====
package tetrisPkg;

	typedef logic [4:0] rowIdxT;	// Board row, 0 is the top
	typedef logic [4:0] colIdxT;	// One spare bit so -1 and Width stay visible
	typedef logic [15:0] scoreT;	// Cleared row count
	typedef logic [1:0] shapeT;

	// Shape codes
	localparam shapeT ShapeSquare = 2'd0;
	localparam shapeT ShapeHBar = 2'd1;
	localparam shapeT ShapeVBar = 2'd2;
	localparam shapeT ShapeT = 2'd3;

	typedef enum logic [2:0] {
		Spawn,
		Play,
		Lock,
		Clear,
		CheckTop,
		Over
	} ctrlStateT;

	// Cell offsets from the anchor, indexed [shape][cell]
	localparam logic [0:3][0:3][1:0] ShapeRowOff = '{
		'{2'd0, 2'd0, 2'd1, 2'd1},	// Square
		'{2'd0, 2'd0, 2'd0, 2'd0},	// Horizontal bar
		'{2'd0, 2'd1, 2'd2, 2'd3},	// Vertical bar
		'{2'd0, 2'd0, 2'd0, 2'd1}	// T
	};

	localparam logic [0:3][0:3][1:0] ShapeColOff = '{
		'{2'd0, 2'd1, 2'd0, 2'd1},
		'{2'd0, 2'd1, 2'd2, 2'd3},
		'{2'd0, 2'd0, 2'd0, 2'd0},
		'{2'd0, 2'd1, 2'd2, 2'd1}
	};

	// Locked cells in these top rows end the game
	localparam int SpawnRows = 4;

	// Width 4..31, height 5..31
	localparam int DefaultWidth = 10;
	localparam int DefaultHeight = 20;

endpackage
